//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_sm83
FILELIST = sm83_lite.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(SIM) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/sm83_alu.sv
`timescale 1ns/1ps

module sm83_alu (
    input  sm83_pkg::alu_op_t op,
    input  sm83_pkg::data_t   acc,
    input  sm83_pkg::data_t   arg,
    input  logic              c_in,
    output sm83_pkg::data_t   res,
    output sm83_pkg::flags_t  flags
);
    import sm83_pkg::*;

    logic       sub;
    logic       cy_in;
    logic       half;  // Carry out of the low nibble
    logic       cy_out;
    logic [3:0] lo;
    logic [3:0] hi;
    data_t      arg_x;
    data_t      sum;

    always_comb begin
        sub   = (op == ALU_SUB) || (op == ALU_SBC) || (op == ALU_CP);
        arg_x = sub ? ~arg : arg;
        case (op)
            ALU_ADC:         cy_in = c_in;
            ALU_SBC:         cy_in = ~c_in;  // a + ~b + 1 - c
            ALU_SUB, ALU_CP: cy_in = 1'b1;
            default:         cy_in = 1'b0;
        endcase

        {half, lo}   = {1'b0, acc[3:0]} + {1'b0, arg_x[3:0]} + {4'b0, cy_in};
        {cy_out, hi} = {1'b0, acc[7:4]} + {1'b0, arg_x[7:4]} + {4'b0, half};
        sum          = {hi, lo};

        case (op)
            ALU_AND: res = acc & arg;
            ALU_XOR: res = acc ^ arg;
            ALU_OR:  res = acc | arg;
            ALU_CP:  res = acc;  // Compare only, A written back unchanged
            default: res = sum;
        endcase

        if (op == ALU_AND || op == ALU_XOR || op == ALU_OR)
            flags = '{f_z: (res == 8'h00), f_n: 1'b0, f_h: 1'b0, f_c: 1'b0};
        else
            // H and C are borrows when subtracting
            flags = '{f_z: (sum == 8'h00), f_n: sub, f_h: half ^ sub, f_c: cy_out ^ sub};
    end

endmodule

//--- hw/sm83_core.sv
`timescale 1ns/1ps

module sm83_core #(
    parameter sm83_pkg::addr_t RESET_PC = 16'h0000
) (
    input  logic            clk,
    input  logic            rst,
    output logic            cyc,
    output logic            stb,
    output logic            we,
    output sm83_pkg::addr_t adr,
    output sm83_pkg::data_t dat_w,
    input  sm83_pkg::data_t dat_r,
    input  logic            ack
);
    import sm83_pkg::*;

    // Sequencer state
    data_t      opcode;
    logic [2:0] step;
    logic       step_end;

    // Control word
    logic    done;
    logic    wr_pc;
    ab_src_t ab_src;
    reg8_t   s_db;
    reg8_t   t_db;
    r_wb_t   r_wb;
    alu_op_t alu_op;
    logic    use_alu_acc;
    rr_wb_t  rr_wb;

    // Datapath
    addr_t  hl;
    addr_t  wz;
    data_t  acc;
    logic   carry;
    data_t  alu_res;
    flags_t alu_flags;

    sm83_sequencer u_seq (
        .clk(clk), .rst(rst),
        .ack(ack), .dat_r(dat_r), .done(done),
        .cyc(cyc), .stb(stb), .step_end(step_end),
        .opcode(opcode), .step(step)
    );

    sm83_decoder u_dec (
        .opcode(opcode), .step(step),
        .done(done), .wr_pc(wr_pc), .we(we),
        .ab_src(ab_src), .s_db(s_db), .t_db(t_db),
        .r_wb(r_wb), .alu_op(alu_op), .use_alu_acc(use_alu_acc),
        .rr_wb(rr_wb)
    );

    sm83_pc_unit #(
        .RESET_PC(RESET_PC)
    ) u_pc (
        .clk(clk), .rst(rst),
        .step_end(step_end), .wr_pc(wr_pc), .ab_src(ab_src),
        .hl(hl), .wz(wz),
        .adr(adr)
    );

    // The data bus byte is also the write data of the Wishbone port
    sm83_regfile u_rf (
        .clk(clk), .rst(rst), .step_end(step_end),
        .s_db(s_db), .t_db(t_db), .r_wb(r_wb),
        .use_alu_acc(use_alu_acc), .rr_wb(rr_wb),
        .dat_r(dat_r), .alu_res(alu_res), .alu_flags(alu_flags),
        .db(dat_w), .acc(acc), .carry(carry),
        .hl(hl), .wz(wz)
    );

    sm83_alu u_alu (
        .op(alu_op), .acc(acc), .arg(dat_w), .c_in(carry),
        .res(alu_res), .flags(alu_flags)
    );

endmodule

//--- hw/sm83_decoder.sv
`timescale 1ns/1ps

module sm83_decoder (
    input  sm83_pkg::data_t   opcode,
    input  logic [2:0]        step,
    output logic              done,
    output logic              wr_pc,
    output logic              we,
    output sm83_pkg::ab_src_t ab_src,
    output sm83_pkg::reg8_t   s_db,
    output sm83_pkg::reg8_t   t_db,
    output sm83_pkg::r_wb_t   r_wb,
    output sm83_pkg::alu_op_t alu_op,
    output logic              use_alu_acc,
    output sm83_pkg::rr_wb_t  rr_wb
);
    import sm83_pkg::*;

    reg8_t  r_dst;
    reg8_t  r_src;
    logic   src_mem;
    logic   dst_mem;
    rr_wb_t rr_sel;

    function automatic reg8_t r8_field(input logic [2:0] f);
        case (f)
            3'd0:    return B;
            3'd1:    return C;
            3'd2:    return D;
            3'd3:    return E;
            3'd4:    return H;
            3'd5:    return L;
            3'd6:    return MEM;  // (HL)
            default: return A;
        endcase
    endfunction

    assign r_dst   = r8_field(opcode[5:3]);
    assign r_src   = r8_field(opcode[2:0]);
    assign src_mem = (r_src == MEM);
    assign dst_mem = (r_dst == MEM);

    always_comb begin
        case (opcode[5:4])
            2'd0:    rr_sel = RR_WB_BC;
            2'd1:    rr_sel = RR_WB_DE;
            2'd2:    rr_sel = RR_WB_HL;
            default: rr_sel = RR_WB_NONE;  // LD SP,nn falls back to NOP
        endcase
    end

    always_comb begin
        // Fetch row: read the next opcode at PC, PC+1
        done        = 1'b1;
        wr_pc       = 1'b1;
        ab_src      = AB_PC;
        s_db        = NONE;
        t_db        = NONE;
        r_wb        = R_WB_DB;
        use_alu_acc = 1'b0;
        rr_wb       = RR_WB_NONE;
        alu_op      = alu_op_t'(opcode[5:3]);

        casez (opcode)
            OP_LD_RR_NN, OP_JP_NN: begin
                if (opcode == OP_JP_NN || rr_sel != RR_WB_NONE) begin
                    if (step < 3'd2) begin
                        // Low byte into Z, then high byte into W
                        done = 1'b0;
                        s_db = MEM;
                        t_db = (step == 3'd0) ? Z : W;
                    end else if (opcode == OP_JP_NN) begin
                        ab_src = AB_WZ;  // Next opcode comes from nn
                    end else begin
                        rr_wb = rr_sel;
                    end
                end
            end
            OP_LD_R_N: begin
                if (!dst_mem) begin
                    if (step == 3'd0) begin
                        done = 1'b0;
                        s_db = MEM;
                        t_db = Z;
                    end else begin
                        s_db = Z;
                        t_db = r_dst;
                    end
                end
            end
            OP_LD_R_R: begin
                if (!(src_mem && dst_mem)) begin  // 0x76 is HALT, runs as NOP
                    if (step == 3'd0 && (src_mem || dst_mem)) begin
                        done   = 1'b0;
                        wr_pc  = 1'b0;
                        ab_src = AB_HL;
                        s_db   = r_src;  // MEM on a load, the register on a store
                        t_db   = src_mem ? Z : MEM;
                    end else if (!dst_mem) begin
                        s_db = src_mem ? Z : r_src;
                        t_db = r_dst;
                    end
                end
            end
            OP_ALU_A_R, OP_ALU_A_N: begin
                if (step == 3'd0 && src_mem) begin
                    done = 1'b0;
                    s_db = MEM;
                    t_db = Z;
                    if (!opcode[6]) begin  // (HL) operand, immediate reads at PC
                        wr_pc  = 1'b0;
                        ab_src = AB_HL;
                    end
                end else begin
                    s_db        = src_mem ? Z : r_src;
                    t_db        = A;
                    r_wb        = R_WB_ALU;
                    use_alu_acc = 1'b1;
                end
            end
            default: done = 1'b1;  // Everything else runs as NOP
        endcase
    end

    assign we = (t_db == MEM);

endmodule

//--- hw/sm83_pc_unit.sv
`timescale 1ns/1ps

module sm83_pc_unit #(
    parameter sm83_pkg::addr_t RESET_PC = 16'h0000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              step_end,
    input  logic              wr_pc,
    input  sm83_pkg::ab_src_t ab_src,
    input  sm83_pkg::addr_t   hl,
    input  sm83_pkg::addr_t   wz,
    output sm83_pkg::addr_t   adr
);
    import sm83_pkg::*;

    addr_t pc;
    addr_t adr_inc;  // Increment unit, always works on the bus address

    always_comb begin
        case (ab_src)
            AB_HL:   adr = hl;
            AB_WZ:   adr = wz;
            default: adr = pc;
        endcase
    end

    assign adr_inc = adr + addr_t'(1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            pc <= RESET_PC;
        else if (step_end && wr_pc)
            pc <= adr_inc;  // WZ+1 here completes a jump
    end

endmodule

//--- hw/sm83_pkg.sv
package sm83_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // 8-bit sources and targets of the data bus, Z..A also index the register array
    typedef enum logic [3:0] {
        NONE, Z, W, B, C, D, E, H, L, A, MEM
    } reg8_t;

    typedef enum logic [1:0] {
        AB_PC, AB_HL, AB_WZ
    } ab_src_t;

    typedef enum logic [1:0] {
        RR_WB_NONE, RR_WB_BC, RR_WB_DE, RR_WB_HL
    } rr_wb_t;

    // Same order as bits [5:3] of the ALU opcodes
    typedef enum logic [2:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_AND, ALU_XOR, ALU_OR, ALU_CP
    } alu_op_t;

    typedef enum logic {
        R_WB_DB, R_WB_ALU
    } r_wb_t;

    typedef struct packed {
        logic f_z;
        logic f_n;
        logic f_h;
        logic f_c;
    } flags_t;

    // Opcode patterns, ? bits are register or operation fields
    localparam data_t OP_NOP      = 8'b0000_0000;
    localparam data_t OP_LD_RR_NN = 8'b00??_0001;
    localparam data_t OP_LD_R_N   = 8'b00??_?110;
    localparam data_t OP_LD_R_R   = 8'b01??_????;  // Includes the (HL) forms
    localparam data_t OP_ALU_A_R  = 8'b10??_????;
    localparam data_t OP_ALU_A_N  = 8'b11??_?110;
    localparam data_t OP_JP_NN    = 8'b1100_0011;

endpackage

//--- hw/sm83_regfile.sv
`timescale 1ns/1ps

module sm83_regfile (
    input  logic             clk,
    input  logic             rst,
    input  logic             step_end,
    input  sm83_pkg::reg8_t  s_db,
    input  sm83_pkg::reg8_t  t_db,
    input  sm83_pkg::r_wb_t  r_wb,
    input  logic             use_alu_acc,
    input  sm83_pkg::rr_wb_t rr_wb,
    input  sm83_pkg::data_t  dat_r,
    input  sm83_pkg::data_t  alu_res,
    input  sm83_pkg::flags_t alu_flags,
    output sm83_pkg::data_t  db,
    output sm83_pkg::data_t  acc,
    output logic             carry,
    output sm83_pkg::addr_t  hl,
    output sm83_pkg::addr_t  wz
);
    import sm83_pkg::*;

    data_t  rf [Z:A];  // Z, W, B, C, D, E, H, L, A
    flags_t flags;
    data_t  wb;

    // Data bus source
    always_comb begin
        case (s_db)
            NONE:    db = '0;
            MEM:     db = dat_r;
            default: db = rf[s_db];
        endcase
    end

    assign wb    = (r_wb == R_WB_ALU) ? alu_res : db;
    assign acc   = rf[A];
    assign carry = flags.f_c;
    assign hl    = {rf[H], rf[L]};
    assign wz    = {rf[W], rf[Z]};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rf    <= '{default: '0};
            flags <= '0;
        end else if (step_end) begin
            if (t_db != NONE && t_db != MEM)
                rf[t_db] <= wb;
            if (use_alu_acc)
                flags <= alu_flags;  // Flags change only on ALU instructions
            // LD rr,nn copies the gathered immediate
            if (rr_wb == RR_WB_BC)
                {rf[B], rf[C]} <= wz;
            else if (rr_wb == RR_WB_DE)
                {rf[D], rf[E]} <= wz;
            else if (rr_wb == RR_WB_HL)
                {rf[H], rf[L]} <= wz;
        end
    end

endmodule

//--- hw/sm83_sequencer.sv
`timescale 1ns/1ps

module sm83_sequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            ack,
    input  sm83_pkg::data_t dat_r,
    input  logic            done,
    output logic            cyc,
    output logic            stb,
    output logic            step_end,
    output sm83_pkg::data_t opcode,
    output logic [2:0]      step
);
    import sm83_pkg::*;

    logic running;  // Set on the first edge after reset, then stays set

    // One Wishbone cycle per step, so cyc and stb stay up between steps
    assign cyc      = running;
    assign stb      = running;
    assign step_end = running & ack;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            running <= 1'b0;
            opcode  <= OP_NOP;  // First step is then a plain fetch
            step    <= 3'd0;
        end else begin
            running <= 1'b1;
            if (step_end) begin
                if (done) begin
                    // Last step read the next opcode
                    opcode <= dat_r;
                    step   <= 3'd0;
                end else begin
                    step <= step + 3'd1;
                end
            end
        end
    end

endmodule

//--- sm83_lite.f
+incdir+verif
hw/sm83_pkg.sv
hw/sm83_alu.sv
hw/sm83_regfile.sv
hw/sm83_pc_unit.sv
hw/sm83_decoder.sv
hw/sm83_sequencer.sv
hw/sm83_core.sv
verif/sm83_assert.sv
verif/tb_sm83.sv

//--- verif/sm83_assert.sv
`timescale 1ns/1ps

module sm83_assert #(
    parameter sm83_pkg::addr_t FIRST_PC = 16'h0000
) (
    input logic            clk,
    input logic            rst,
    input logic            cyc,
    input logic            stb,
    input logic            we,
    input sm83_pkg::addr_t adr,
    input sm83_pkg::data_t dat_w,
    input logic            ack
);
    int unsigned fail_count = 0;  // Read by the testbench at the end of the run

    // Bus stays idle while reset is held
    a_reset_idle: assert property (@(posedge clk) !rst |-> (!cyc && !stb && !we))
        else begin
            $error("Bus active while reset is low");
            fail_count++;
        end

    a_first_fetch: assert property (@(posedge clk) disable iff (!rst)
        $rose(stb) |-> (!we && adr == FIRST_PC))
        else begin
            $error("First cycle after reset is not a read at the reset address");
            fail_count++;
        end

    a_stb_cyc: assert property (@(posedge clk) disable iff (!rst) stb |-> cyc)
        else begin
            $error("stb high without cyc");
            fail_count++;
        end

    // Request held until ack
    a_req_stable: assert property (@(posedge clk) disable iff (!rst)
        (stb && !ack) |=> (stb && $stable(adr) && $stable(we)))
        else begin
            $error("adr or we changed before ack");
            fail_count++;
        end

    a_wdata_stable: assert property (@(posedge clk) disable iff (!rst)
        (stb && we && !ack) |=> $stable(dat_w))
        else begin
            $error("dat_w changed before ack on a write");
            fail_count++;
        end

endmodule

bind sm83_core sm83_assert #(.FIRST_PC(RESET_PC)) u_chk (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we),
    .adr(adr), .dat_w(dat_w), .ack(ack)
);

//--- verif/tb_program.svh
// Main program at 0100, ends in a JP over a trap store
localparam logic [7:0] MAIN_CODE [0:59] = '{
    8'h21, 8'h00, 8'hC0,  // LD HL,C000
    8'h06, 8'h5A,         // LD B,5A
    8'h70,                // LD (HL),B
    8'h48,                // LD C,B
    8'h21, 8'h01, 8'hC0,  // LD HL,C001
    8'h71,                // LD (HL),C
    8'h7E,                // LD A,(HL) reads the byte back
    8'h21, 8'h02, 8'hC0,  // LD HL,C002
    8'h77,                // LD (HL),A
    8'h3E, 8'h3C,         // LD A,3C
    8'hC6, 8'hD5, 8'h77,  // ADD A,D5
    8'h16, 8'h27,         // LD D,27
    8'h92, 8'h77,         // SUB A,D
    8'hE6, 8'h0F, 8'h77,  // AND A,0F
    8'h1E, 8'h5C,         // LD E,5C
    8'hAB, 8'h77,         // XOR A,E
    8'h3E, 8'h81,         // LD A,81
    8'hB6, 8'h77,         // OR A,(HL)
    8'h86, 8'h77,         // ADD A,(HL)
    8'hFE, 8'h40,         // CP A,40
    8'hBA, 8'h77,         // CP A,D then store A
    8'h3E, 8'hF0,         // LD A,F0
    8'hC6, 8'h20,         // ADD A,20 sets carry
    8'hCE, 8'h01, 8'h77,  // ADC A,01 takes it in and clears it
    8'hDE, 8'h05, 8'h77,  // SBC A,05 with carry clear
    8'hD6, 8'h20,         // SUB A,20 borrows
    8'h9A, 8'h77,         // SBC A,D with carry set
    8'hC3, 8'h00, 8'h02,  // JP 0200
    8'h70                 // Trap store, skipped by the jump
};

// Jump target, marker store then a tight loop
localparam logic [7:0] TAIL_CODE [0:6] = '{
    8'h21, 8'hFF, 8'hFF,  // LD HL,FFFF
    8'h77,                // LD (HL),A
    8'hC3, 8'h04, 8'h02   // JP 0204
};

task automatic load_program();
    for (int i = 0; i < 60; i++)
        mem[16'h0100 + i] = MAIN_CODE[i];
    for (int i = 0; i < 7; i++)
        mem[16'h0200 + i] = TAIL_CODE[i];
endtask

// Expected stores in program order, ALU results come from the reference model
task automatic build_expected();
    expect_store("loads", 16'hC000, 8'h5A);
    expect_store("loads", 16'hC001, 8'h5A);
    expect_store("loads", 16'hC002, 8'h5A);
    model_a = 8'h3C;
    model_c = 1'b0;
    model_alu(ADD_OP, 8'hD5);
    expect_store("alu", 16'hC002, model_a);
    model_alu(SUB_OP, 8'h27);
    expect_store("alu", 16'hC002, model_a);
    model_alu(AND_OP, 8'h0F);
    expect_store("alu", 16'hC002, model_a);
    model_alu(XOR_OP, 8'h5C);
    expect_store("alu", 16'hC002, model_a);
    model_a = 8'h81;
    model_alu(OR_OP, model_m);
    expect_store("alu", 16'hC002, model_a);
    model_alu(ADD_OP, model_m);
    expect_store("alu", 16'hC002, model_a);
    model_alu(CP_OP, 8'h40);
    model_alu(CP_OP, 8'h27);
    expect_store("alu", 16'hC002, model_a);
    model_a = 8'hF0;
    model_alu(ADD_OP, 8'h20);
    model_alu(ADC_OP, 8'h01);
    expect_store("carry", 16'hC002, model_a);
    model_alu(SBC_OP, 8'h05);
    expect_store("carry", 16'hC002, model_a);
    model_alu(SUB_OP, 8'h20);
    model_alu(SBC_OP, 8'h27);
    expect_store("carry", 16'hC002, model_a);
    expect_store("jump", 16'hFFFF, model_a);  // Marker
endtask

//--- verif/tb_sm83.sv
`timescale 1ns/1ps

module tb_sm83;

    typedef enum int {
        ADD_OP, ADC_OP, SUB_OP, SBC_OP, AND_OP, XOR_OP, OR_OP, CP_OP
    } ref_op_t;

    logic        clk;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic        ack;
    logic [15:0] adr;
    logic [7:0]  dat_w;
    logic [7:0]  dat_r;

    logic [7:0]  mem [0:65535];
    logic        pending;     // Request seen, ack not yet given
    int          wait_left;
    logic [15:0] req_adr;
    logic        req_we;
    logic [7:0]  req_dat;

    string       exp_name [$];
    logic [15:0] exp_adr [$];
    logic [7:0]  exp_dat [$];
    int          exp_idx = 0;
    int          errors = 0;
    int          timeouts = 0;
    int          tests_done = 0;
    int          test_err_base = 0;
    int          test_stores = 0;
    logic        marker_seen = 1'b0;
    logic [7:0]  model_a;
    logic        model_c;
    logic [7:0]  model_m;     // Last byte stored, what (HL) reads back

    sm83_core #(.RESET_PC(16'h0100)) dut0 (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we),
        .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    always #5 clk = ~clk;

    task automatic expect_store(input string name, input logic [15:0] a, input logic [7:0] d);
        exp_name.push_back(name);
        exp_adr.push_back(a);
        exp_dat.push_back(d);
        model_m = d;
    endtask

    // Reference ALU on plain integers, carry means carry out or borrow
    task automatic model_alu(input ref_op_t op, input logic [7:0] b);
        int x;
        int y;
        int s;
        x = model_a;
        y = b;
        case (op)
            ADD_OP:        s = x + y;
            ADC_OP:        s = x + y + int'(model_c);
            SUB_OP, CP_OP: s = x - y;
            SBC_OP:        s = x - y - int'(model_c);
            AND_OP:        s = x & y;
            XOR_OP:        s = x ^ y;
            default:       s = x | y;
        endcase
        if (op != CP_OP)
            model_a = s[7:0];
        model_c = (s < 0) || (s > 255);
    endtask

    `include "tb_program.svh"

    task automatic check_store(input logic [15:0] a, input logic [7:0] d);
        string name;
        if (a == 16'hFFFF)
            marker_seen = 1'b1;
        if (exp_idx >= exp_adr.size()) begin
            $display("Unexpected store of %02h to %04h after the last expected store", d, a);
            errors++;
        end else begin
            name = exp_name[exp_idx];
            assert (a == exp_adr[exp_idx] && d == exp_dat[exp_idx])
            else begin
                $display("ERROR %s: expected %04h=%02h, actual %04h=%02h",
                         name, exp_adr[exp_idx], exp_dat[exp_idx], a, d);
                errors++;
            end
            exp_idx++;
            test_stores++;
            if (exp_idx == exp_adr.size() || exp_name[exp_idx] != name) begin
                $display("%s: %s after %0d stores", name,
                         (errors == test_err_base) ? "ok" : "failed", test_stores);
                tests_done++;
                test_err_base = errors;
                test_stores = 0;
            end
        end
    endtask

    // Wishbone slave with 0 to 3 wait cycles, outputs change just after the edge
    always @(posedge clk) begin
        #1;
        if (ack) begin
            if (req_we) begin
                mem[req_adr] = req_dat;
                check_store(req_adr, req_dat);
            end
            ack = 1'b0;
            pending = 1'b0;
        end
        if (rst && cyc && stb) begin
            if (!pending) begin
                pending = 1'b1;
                wait_left = $urandom % 4;
            end
            if (wait_left == 0) begin
                req_adr = adr;
                req_we = we;
                req_dat = dat_w;
                if (!we)
                    dat_r = mem[adr];
                ack = 1'b1;
            end else begin
                wait_left--;
            end
        end
    end

    task automatic wait_for_marker(input int max_cycles);
        int n;
        n = 0;
        while (!marker_seen && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (!marker_seen) begin
            $display("Timeout: no store to FFFF within %0d cycles", max_cycles);
            timeouts++;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        ack = 1'b0;
        dat_r = 8'h00;
        pending = 1'b0;
        wait_left = 0;
        void'($urandom(88));
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'(i ^ (i >> 8));  // Fill differs with both address bytes
        load_program();
        build_expected();
        repeat (10) @(posedge clk);
        #1 rst = 1'b1;
        wait_for_marker(5000);
        if (exp_idx != exp_adr.size())
            $display("Only %0d of %0d expected stores arrived", exp_idx, exp_adr.size());
        $display("Tests: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
                 tests_done, errors, timeouts, dut0.u_chk.fail_count);
        if (errors == 0 && timeouts == 0 && dut0.u_chk.fail_count == 0
                && exp_idx == exp_adr.size())
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
